/* hdl/synth_consts.svh */
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// voice and slot geometry
`define SYN_VOICES      4
`define SYN_V_OSC       4
`define SYN_SLOTS       (`SYN_VOICES * `SYN_V_OSC)
`define SYN_V_WIDTH     2
`define SYN_O_WIDTH     2

// datapath widths
`define SYN_AUD_BITS    24
`define SYN_MOD_BITS    11

// register map, byte addresses on the 7-bit register bus
`define SYN_ADR_LVL     7'h00   // + osc index
`define SYN_ADR_PAN     7'h08   // + osc index
`define SYN_ADR_MSRC    7'h10   // + osc index
`define SYN_ADR_MDEPTH  7'h18   // + osc index
`define SYN_ADR_MVOL    7'h20

`define SYN_PAN_CENTER  8'd64
`define SYN_MVOL_INIT   8'd127

`endif

/* hdl/synth_pkg.sv */
`default_nettype none

`include "synth_consts.svh"

package synth_pkg;

    // position of one slot inside the frame, slot index = voice * 4 + osc
    typedef struct packed {
        logic [`SYN_V_WIDTH-1:0] voice;
        logic [`SYN_O_WIDTH-1:0] osc;
    } slot_t;

    // what the oscillator engine presents for one slot
    typedef struct packed {
        logic signed [7:0]  env;    // envelope level
        logic signed [16:0] sine;   // sine table output
    } slot_in_t;

    // per-oscillator patch fields
    typedef struct packed {
        logic [7:0] level;  // unsigned
        logic [7:0] pan;    // 0 = full left
        logic [7:0] msrc;   // source osc in low bits
        logic [7:0] depth;  // signed
    } osc_patch_t;

    typedef struct packed {
        osc_patch_t [`SYN_V_OSC-1:0] osc;
        logic [7:0]                  mvol;
    } patch_t;

endpackage

`default_nettype wire

/* hdl/slot_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_consts.svh"

module slot_sequencer import synth_pkg::*; (
    input  wire logic sCLK_XVXENVS,
    input  wire logic arst_n,
    input  wire logic frame_start,
    input  slot_in_t  slot_in,
    output slot_t     slot,
    output slot_in_t  slot_in_q,
    output logic      slot_valid,
    output logic      last_slot,
    output logic      frame_start_q
);

    logic [`SYN_V_WIDTH+`SYN_O_WIDTH-1:0] nxt_idx;
    logic                                 nxt_valid;

    // a new strobe always wins, even in the middle of a frame
    always_comb begin
        if (frame_start) begin
            nxt_idx   = '0;
            nxt_valid = 1'b1;
        end else if (slot_valid && !last_slot) begin
            nxt_idx   = slot + 1'b1;    // slot_t packs as the flat index
            nxt_valid = 1'b1;
        end else begin
            nxt_idx   = slot;
            nxt_valid = 1'b0;           // idle after slot 15
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            slot          <= '0;
            slot_valid    <= 1'b0;
            last_slot     <= 1'b0;
            frame_start_q <= 1'b0;
        end else begin
            slot          <= slot_t'(nxt_idx);
            slot_valid    <= nxt_valid;
            last_slot     <= nxt_valid && (nxt_idx == `SYN_SLOTS - 1);
            frame_start_q <= frame_start;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        slot_in_q <= slot_in;   // travels with its index
    end

endmodule

`default_nettype wire

/* hdl/patch_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_consts.svh"

module patch_regs import synth_pkg::*; (
    input  wire logic       sCLK_XVXENVS,
    input  wire logic       arst_n,
    input  wire logic [6:0] adr,
    input  wire logic [7:0] wr_data,
    input  wire logic       write,
    input  wire logic       read,
    output patch_t          patch,
    output logic      [7:0] rd_data,
    output logic            rd_valid
);

    patch_t                  regs;
    logic [6:0]              region;
    logic [`SYN_O_WIDTH-1:0] oi;
    logic                    osc_hit;
    logic [7:0]              rd_mux;

    assign region  = {adr[6:3], 3'b000};
    assign oi      = adr[`SYN_O_WIDTH-1:0];
    assign osc_hit = (adr[2:`SYN_O_WIDTH] == '0);   // only 4 of 8 slots per field
    assign patch   = regs;

    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < `SYN_V_OSC; o++) begin
                regs.osc[o].level <= 8'd0;
                regs.osc[o].pan   <= `SYN_PAN_CENTER;
                regs.osc[o].msrc  <= 8'd0;
                regs.osc[o].depth <= 8'd0;
            end
            regs.mvol <= `SYN_MVOL_INIT;
        end else if (write) begin
            if (adr == `SYN_ADR_MVOL) begin
                regs.mvol <= wr_data;
            end else if (osc_hit) begin
                case (region)
                    `SYN_ADR_LVL:    regs.osc[oi].level <= wr_data;
                    `SYN_ADR_PAN:    regs.osc[oi].pan   <= wr_data;
                    `SYN_ADR_MSRC:   regs.osc[oi].msrc  <= wr_data;
                    `SYN_ADR_MDEPTH: regs.osc[oi].depth <= wr_data;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_mux = 8'd0;      // unmapped reads as zero
        if (adr == `SYN_ADR_MVOL) begin
            rd_mux = regs.mvol;
        end else if (osc_hit) begin
            case (region)
                `SYN_ADR_LVL:    rd_mux = regs.osc[oi].level;
                `SYN_ADR_PAN:    rd_mux = regs.osc[oi].pan;
                `SYN_ADR_MSRC:   rd_mux = regs.osc[oi].msrc;
                `SYN_ADR_MDEPTH: rd_mux = regs.osc[oi].depth;
                default:         rd_mux = 8'd0;
            endcase
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            rd_data  <= 8'd0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= read;
            if (read) rd_data <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* hdl/mod_matrix.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_consts.svh"

module mod_matrix import synth_pkg::*; (
    input  wire logic sCLK_XVXENVS,
    input  wire logic arst_n,
    input  slot_t     slot,
    input  slot_in_t  slot_in_q,
    input  wire logic slot_valid,
    input  wire logic frame_start_q,
    input  patch_t    patch,
    output logic signed [`SYN_MOD_BITS-1:0] modulation,
    output logic      mod_valid
);

    logic [7:0]                           bank0 [`SYN_SLOTS];
    logic [7:0]                           bank1 [`SYN_SLOTS];
    logic                                 bank_sel;
    logic                                 wr_bank;
    logic [`SYN_V_WIDTH+`SYN_O_WIDTH-1:0] rd_idx;
    osc_patch_t                           cur;
    logic signed [24:0]                   osc_prod;
    logic signed [24:0]                   osc_shift;
    logic signed [7:0]                    src_val;
    logic signed [15:0]                   mod_prod;
    logic signed [15:0]                   mod_shift;

    // the strobe flips the bank in the same cycle as slot 0
    assign wr_bank = bank_sel ^ frame_start_q;

    assign cur       = patch.osc[slot.osc];
    assign osc_prod  = $signed(slot_in_q.sine) * $signed(slot_in_q.env);
    assign osc_shift = osc_prod >>> 9;

    assign rd_idx  = {slot.voice, cur.msrc[`SYN_O_WIDTH-1:0]};  // same voice
    assign src_val = wr_bank ? $signed(bank0[rd_idx]) : $signed(bank1[rd_idx]);

    assign mod_prod  = src_val * $signed(cur.depth);
    assign mod_shift = mod_prod >>> 7;

    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            bank_sel <= 1'b0;
            for (int i = 0; i < `SYN_SLOTS; i++) begin
                bank0[i] <= 8'd0;   // first frame modulates with zero
                bank1[i] <= 8'd0;
            end
        end else if (slot_valid) begin
            bank_sel <= wr_bank;
            if (wr_bank) begin
                bank1[slot] <= osc_shift[7:0];
            end else begin
                bank0[slot] <= osc_shift[7:0];
            end
        end
    end

    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            mod_valid <= 1'b0;
        end else begin
            mod_valid <= slot_valid;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (slot_valid) modulation <= mod_shift[`SYN_MOD_BITS-1:0];
    end

endmodule

`default_nettype wire

/* hdl/voice_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_consts.svh"

module voice_mixer import synth_pkg::*; (
    input  wire logic                    sCLK_XVXENVS,
    input  wire logic                    arst_n,
    input  slot_t                        slot,
    input  slot_in_t                     slot_in_q,
    input  wire logic                    slot_valid,
    input  wire logic                    last_slot,
    input  patch_t                       patch,
    input  wire logic [`SYN_VOICES-1:0]  active_keys,
    output logic signed [`SYN_AUD_BITS-1:0] l_sample,
    output logic signed [`SYN_AUD_BITS-1:0] r_sample,
    output logic                         sample_valid
);

    localparam int AUD = `SYN_AUD_BITS;
    localparam logic signed [34:0] AUD_MAX = (35'sd1 <<< (AUD - 1)) - 35'sd1;
    localparam logic signed [34:0] AUD_MIN = -(35'sd1 <<< (AUD - 1));

    function automatic logic signed [AUD-1:0] sat_aud(input logic signed [34:0] v);
        logic signed [AUD-1:0] res;
        if (v > AUD_MAX) res = AUD_MAX[AUD-1:0];
        else if (v < AUD_MIN) res = AUD_MIN[AUD-1:0];
        else res = v[AUD-1:0];
        return res;
    endfunction

    logic signed [33:0] full_prod;
    logic signed [33:0] full_shift;
    logic               s1_valid, s1_last;
    slot_t              s1_slot;
    logic signed [19:0] s1_contrib;

    logic signed [8:0]  pan_r_w, pan_l_w;
    logic signed [28:0] prod_l, prod_r;
    logic signed [28:0] shl, shr;
    logic               s2_valid, s2_last;
    slot_t              s2_slot;
    logic signed [21:0] s2_l, s2_r;

    logic signed [25:0] acc_l, acc_r;
    logic signed [25:0] acc_l_nxt, acc_r_nxt;
    logic signed [34:0] vol_l, vol_r;

    // stage 1: gated sine * env * level
    assign full_prod  = $signed(slot_in_q.sine) * $signed(slot_in_q.env)
                      * $signed({1'b0, patch.osc[slot.osc].level});
    assign full_shift = full_prod >>> 14;

    always_ff @(posedge sCLK_XVXENVS) begin
        s1_slot    <= slot;
        s1_last    <= last_slot;
        s1_contrib <= active_keys[slot.voice] ? full_shift[19:0] : 20'sd0;  // key off
    end

    // stage 2: pan weighting
    assign pan_r_w = $signed({1'b0, patch.osc[s1_slot.osc].pan});
    assign pan_l_w = 9'sd127 - pan_r_w;
    assign prod_l  = s1_contrib * pan_l_w;
    assign prod_r  = s1_contrib * pan_r_w;
    assign shl     = prod_l >>> 7;
    assign shr     = prod_r >>> 7;

    always_ff @(posedge sCLK_XVXENVS) begin
        s2_slot <= s1_slot;
        s2_last <= s1_last;
        s2_l    <= shl[21:0];
        s2_r    <= shr[21:0];
    end

    // stage 3: accumulate, restart at slot 0
    assign acc_l_nxt = ((s2_slot == '0) ? 26'sd0 : acc_l) + s2_l;
    assign acc_r_nxt = ((s2_slot == '0) ? 26'sd0 : acc_r) + s2_r;
    assign vol_l     = (acc_l_nxt * $signed({1'b0, patch.mvol})) >>> 7;
    assign vol_r     = (acc_r_nxt * $signed({1'b0, patch.mvol})) >>> 7;

    always_ff @(posedge sCLK_XVXENVS or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            acc_l        <= '0;
            acc_r        <= '0;
            l_sample     <= '0;
            r_sample     <= '0;
            sample_valid <= 1'b0;
        end else begin
            s1_valid     <= slot_valid;
            s2_valid     <= s1_valid;
            sample_valid <= s2_valid && s2_last;
            if (s2_valid) begin
                acc_l <= acc_l_nxt;
                acc_r <= acc_r_nxt;
                if (s2_last) begin
                    l_sample <= sat_aud(vol_l);
                    r_sample <= sat_aud(vol_r);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fm_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_consts.svh"

module fm_mixer import synth_pkg::*; (
    input  wire logic                       sCLK_XVXENVS,
    input  wire logic                       arst_n,
    input  wire logic                       frame_start,
    input  slot_in_t                        slot_in,
    input  wire logic [`SYN_VOICES-1:0]     active_keys,
    input  wire logic [6:0]                 adr,
    input  wire logic [7:0]                 wr_data,
    input  wire logic                       write,
    input  wire logic                       read,
    output logic [7:0]                      rd_data,
    output logic                            rd_valid,
    output logic signed [`SYN_MOD_BITS-1:0] modulation,
    output logic                            mod_valid,
    output logic signed [`SYN_AUD_BITS-1:0] l_sample,
    output logic signed [`SYN_AUD_BITS-1:0] r_sample,
    output logic                            sample_valid
);

    slot_t    slot;
    slot_in_t slot_in_q;
    logic     slot_valid;
    logic     last_slot;
    logic     frame_start_q;
    patch_t   patch;

    slot_sequencer u_seq (
        .sCLK_XVXENVS  (sCLK_XVXENVS),
        .arst_n        (arst_n),
        .frame_start   (frame_start),
        .slot_in       (slot_in),
        .slot          (slot),
        .slot_in_q     (slot_in_q),
        .slot_valid    (slot_valid),
        .last_slot     (last_slot),
        .frame_start_q (frame_start_q)
    );

    patch_regs u_regs (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .arst_n       (arst_n),
        .adr          (adr),
        .wr_data      (wr_data),
        .write        (write),
        .read         (read),
        .patch        (patch),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid)
    );

    mod_matrix u_mod (
        .sCLK_XVXENVS  (sCLK_XVXENVS),
        .arst_n        (arst_n),
        .slot          (slot),
        .slot_in_q     (slot_in_q),
        .slot_valid    (slot_valid),
        .frame_start_q (frame_start_q),
        .patch         (patch),
        .modulation    (modulation),
        .mod_valid     (mod_valid)
    );

    voice_mixer u_mix (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .arst_n       (arst_n),
        .slot         (slot),
        .slot_in_q    (slot_in_q),
        .slot_valid   (slot_valid),
        .last_slot    (last_slot),
        .patch        (patch),
        .active_keys  (active_keys),
        .l_sample     (l_sample),
        .r_sample     (r_sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

/* verification/fm_mixer_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_mixer_checker (
    input wire logic sCLK_XVXENVS,
    input wire logic arst_n,
    input wire logic read,
    input wire logic rd_valid,
    input wire logic slot_valid,
    input wire logic last_slot,
    input wire logic mod_valid,
    input wire logic sample_valid
);

    int fail_count = 0;     // read by the testbench at the end of the run

    sample_one_cycle: assert property (@(posedge sCLK_XVXENVS) disable iff (!arst_n)
        sample_valid |=> !sample_valid)
        else begin
            $error("sample_valid held for more than one cycle");
            fail_count++;
        end

    // slot 15 is registered one cycle after its input cycle
    sample_after_last: assert property (@(posedge sCLK_XVXENVS) disable iff (!arst_n)
        (slot_valid && last_slot) |-> ##3 sample_valid)
        else begin
            $error("sample_valid missing after the last slot");
            fail_count++;
        end

    sample_has_cause: assert property (@(posedge sCLK_XVXENVS) disable iff (!arst_n)
        sample_valid |-> $past(slot_valid && last_slot, 3))
        else begin
            $error("sample_valid without a last slot before it");
            fail_count++;
        end

    rd_follows_read: assert property (@(posedge sCLK_XVXENVS) disable iff (!arst_n)
        rd_valid == $past(read))
        else begin
            $error("rd_valid does not follow read by one cycle");
            fail_count++;
        end

    mod_follows_slot: assert property (@(posedge sCLK_XVXENVS) disable iff (!arst_n)
        mod_valid == $past(slot_valid))
        else begin
            $error("mod_valid does not follow slot_valid by one cycle");
            fail_count++;
        end

endmodule

`default_nettype wire

/* verification/fm_mixer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_consts.svh"

module fm_mixer_tb import synth_pkg::*; ();

    logic                            sCLK_XVXENVS;
    logic                            arst_n;
    logic                            frame_start;
    slot_in_t                        slot_in;
    logic [`SYN_VOICES-1:0]          active_keys;
    logic [6:0]                      adr;
    logic [7:0]                      wr_data;
    logic                            write;
    logic                            read;
    logic [7:0]                      rd_data;
    logic                            rd_valid;
    logic signed [`SYN_MOD_BITS-1:0] modulation;
    logic                            mod_valid;
    logic signed [`SYN_AUD_BITS-1:0] l_sample;
    logic signed [`SYN_AUD_BITS-1:0] r_sample;
    logic                            sample_valid;

    logic [7:0]                      reg_m [128];           // register mirror by address
    byte                             prev_out [`SYN_SLOTS]; // last frame's stored outputs
    slot_in_t                        frame_in [`SYN_SLOTS];
    logic signed [`SYN_MOD_BITS-1:0] exp_mod_q [$];
    logic signed [`SYN_AUD_BITS-1:0] exp_l_q [$];
    logic signed [`SYN_AUD_BITS-1:0] exp_r_q [$];
    int                              errors;
    string                           test_name;

    fm_mixer u_dut (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .arst_n       (arst_n),
        .frame_start  (frame_start),
        .slot_in      (slot_in),
        .active_keys  (active_keys),
        .adr          (adr),
        .wr_data      (wr_data),
        .write        (write),
        .read         (read),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .modulation   (modulation),
        .mod_valid    (mod_valid),
        .l_sample     (l_sample),
        .r_sample     (r_sample),
        .sample_valid (sample_valid)
    );

    bind fm_mixer fm_mixer_checker u_chk (.*);

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever #2 sCLK_XVXENVS = ~sCLK_XVXENVS;
    end

    function automatic bit is_mapped(input logic [6:0] a);
        return (a == `SYN_ADR_MVOL) || (a < `SYN_ADR_MVOL && !a[2]);
    endfunction

    function automatic byte osc_out(input slot_in_t x);
        longint p;
        p = (longint'($signed(x.sine)) * longint'($signed(x.env))) >>> 9;
        return byte'(p[7:0]);   // keep low 8 bits
    endfunction

    function automatic logic signed [`SYN_MOD_BITS-1:0] mod_model(input int s);
        int     src;
        longint p;
        src = (s / 4) * 4 + reg_m[`SYN_ADR_MSRC + s % 4][1:0];   // same voice
        p   = longint'(prev_out[src]) * longint'($signed(reg_m[`SYN_ADR_MDEPTH + s % 4]));
        p   = p >>> 7;
        return p[`SYN_MOD_BITS-1:0];
    endfunction

    function automatic longint sat_24(input longint v);
        longint hi;
        hi = (longint'(1) << (`SYN_AUD_BITS - 1)) - 1;
        if (v > hi) return hi;
        if (v < -hi - 1) return -hi - 1;
        return v;
    endfunction

    function automatic void sample_model(output longint l, output longint r);
        longint c;
        longint pan;
        l = 0;
        r = 0;
        for (int s = 0; s < `SYN_SLOTS; s++) begin
            c   = longint'($signed(frame_in[s].sine)) * longint'($signed(frame_in[s].env))
                * longint'(reg_m[`SYN_ADR_LVL + s % 4]);
            c   = active_keys[s / 4] ? (c >>> 14) : 0;
            pan = longint'(reg_m[`SYN_ADR_PAN + s % 4]);
            l  += (c * (127 - pan)) >>> 7;
            r  += (c * pan) >>> 7;
        end
        l = sat_24((l * longint'(reg_m[`SYN_ADR_MVOL])) >>> 7);
        r = sat_24((r * longint'(reg_m[`SYN_ADR_MVOL])) >>> 7);
    endfunction

    task automatic next_cycle();
        @(posedge sCLK_XVXENVS);
        #1;
    endtask

    task automatic write_reg(input logic [6:0] a, input logic [7:0] d);
        next_cycle();
        adr     = a;
        wr_data = d;
        write   = 1'b1;
        next_cycle();
        write   = 1'b0;
        if (is_mapped(a)) reg_m[a] = d;
    endtask

    task automatic check_read(input logic [6:0] a);
        logic [7:0] expv;
        int         t;
        expv = is_mapped(a) ? reg_m[a] : 8'd0;  // holes read 0
        next_cycle();
        adr  = a;
        read = 1'b1;
        next_cycle();
        read = 1'b0;
        t    = 0;
        while (!rd_valid && t < 8) begin
            @(negedge sCLK_XVXENVS);
            t++;
        end
        if (!rd_valid) begin
            $display("timeout: no read response for address %h", a);
            errors++;
        end else begin
            assert (rd_data == expv) else begin
                $display("FAILED %s adr %h: expected %h actual %h", test_name, a, expv, rd_data);
                errors++;
            end
        end
    endtask

    task automatic randomize_patch();
        for (int o = 0; o < `SYN_V_OSC; o++) begin
            write_reg(7'(`SYN_ADR_LVL + o), 8'($urandom));
            write_reg(7'(`SYN_ADR_PAN + o), 8'($urandom_range(127)));
            write_reg(7'(`SYN_ADR_MSRC + o), 8'($urandom));
            write_reg(7'(`SYN_ADR_MDEPTH + o), 8'($urandom));
        end
        write_reg(`SYN_ADR_MVOL, 8'($urandom_range(127)));
    endtask

    task automatic run_frame(input bit loud);
        longint l_exp;
        longint r_exp;
        for (int s = 0; s < `SYN_SLOTS; s++) begin
            frame_in[s] = loud ? slot_in_t'({8'h80, 17'h10000}) : slot_in_t'(25'($urandom));
            exp_mod_q.push_back(mod_model(s));
        end
        sample_model(l_exp, r_exp);
        exp_l_q.push_back(l_exp[`SYN_AUD_BITS-1:0]);
        exp_r_q.push_back(r_exp[`SYN_AUD_BITS-1:0]);
        for (int s = 0; s < `SYN_SLOTS; s++) prev_out[s] = osc_out(frame_in[s]);
        for (int s = 0; s < `SYN_SLOTS; s++) begin
            next_cycle();
            frame_start = (s == 0);
            slot_in     = frame_in[s];
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while ((exp_mod_q.size() != 0 || exp_l_q.size() != 0) && t < 64) begin
            next_cycle();
            t++;
        end
        if (exp_mod_q.size() != 0 || exp_l_q.size() != 0) begin
            $display("timeout: %s still expects %0d modulation and %0d sample results",
                     test_name, exp_mod_q.size(), exp_l_q.size());
            errors++;
            exp_mod_q.delete();
            exp_l_q.delete();
            exp_r_q.delete();
        end
    endtask

    // compares every result the DUT flags as valid
    always @(negedge sCLK_XVXENVS) begin
        logic signed [`SYN_MOD_BITS-1:0] em;
        logic signed [`SYN_AUD_BITS-1:0] el;
        logic signed [`SYN_AUD_BITS-1:0] er;
        if (mod_valid) begin
            assert (exp_mod_q.size() != 0) else begin
                $display("mod_valid pulsed with no modulation expected in %s", test_name);
                errors++;
            end
            if (exp_mod_q.size() != 0) begin
                em = exp_mod_q.pop_front();
                assert (modulation == em) else begin
                    $display("FAILED %s modulation: expected %0d actual %0d",
                             test_name, em, modulation);
                    errors++;
                end
            end
        end
        if (sample_valid) begin
            assert (exp_l_q.size() != 0) else begin
                $display("sample_valid pulsed with no sample expected in %s", test_name);
                errors++;
            end
            if (exp_l_q.size() != 0) begin
                el = exp_l_q.pop_front();
                er = exp_r_q.pop_front();
                assert (l_sample == el && r_sample == er) else begin
                    $display("FAILED %s sample: expected %0d/%0d actual %0d/%0d",
                             test_name, el, er, l_sample, r_sample);
                    errors++;
                end
            end
        end
    end

    initial begin
        void'($urandom(38));
        errors      = 0;
        test_name   = "reset_defaults";
        arst_n      = 1'b0;
        frame_start = 1'b0;
        slot_in     = '0;
        active_keys = '0;
        adr         = '0;
        wr_data     = '0;
        write       = 1'b0;
        read        = 1'b0;
        for (int a = 0; a < 128; a++) reg_m[a] = 8'd0;
        for (int o = 0; o < `SYN_V_OSC; o++) reg_m[`SYN_ADR_PAN + o] = 8'd64;  // centre pan
        reg_m[`SYN_ADR_MVOL] = 8'd127;
        for (int s = 0; s < `SYN_SLOTS; s++) prev_out[s] = 0;
        repeat (16) @(posedge sCLK_XVXENVS);
        #1 arst_n = 1'b1;

        assert (!mod_valid && !sample_valid && !rd_valid && l_sample == 0 && r_sample == 0)
        else begin
            $display("a strobe or sample is not at its reset value after reset");
            errors++;
        end
        for (int a = 0; a < 128; a++) check_read(7'(a));

        test_name = "reg_readback";
        for (int a = 0; a < 128; a++) begin
            write_reg(7'(a), 8'($urandom));
            check_read(7'(a));
        end

        test_name   = "stereo_mix";     // first frame also checks zero modulation
        active_keys = 4'hF;
        repeat (3) begin
            randomize_patch();
            run_frame(1'b0);
            wait_drain();
        end
        for (int o = 0; o < `SYN_V_OSC; o++) begin
            write_reg(7'(`SYN_ADR_LVL + o), 8'd255);
            write_reg(7'(`SYN_ADR_PAN + o), 8'd0);
        end
        write_reg(`SYN_ADR_MVOL, 8'd255);   // loudest case
        run_frame(1'b1);
        wait_drain();

        test_name = "voice_gating";
        randomize_patch();
        active_keys = 4'b1110;
        repeat (4) begin
            run_frame(1'b0);
            wait_drain();
            active_keys = active_keys >> 1;
        end

        test_name   = "mod_routing";
        active_keys = 4'hF;
        repeat (3) begin
            randomize_patch();
            run_frame(1'b0);
            wait_drain();
        end

        test_name = "frame_restart";
        run_frame(1'b0);
        run_frame(1'b0);    // starts right after slot 15
        wait_drain();
        repeat (8) next_cycle();

        $display("testbench errors: %0d, assertion failures: %0d",
                 errors, u_dut.u_chk.fail_count);
        if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/synth_pkg.sv
hdl/slot_sequencer.sv
hdl/patch_regs.sv
hdl/mod_matrix.sv
hdl/voice_mixer.sv
hdl/fm_mixer.sv
verification/fm_mixer_checker.sv
verification/fm_mixer_tb.sv
